// ==== rtl/tag_store_pkg.sv ====
package tag_store_pkg;

  // Cache geometry
  localparam int NUM_WAYS = 4;
  localparam int SETS     = 16;
  localparam int INDEX_W  = 4;
  localparam int TAG_W    = 8;
  // Width of a binary way number
  localparam int WAY_W    = 2;

  // XORed with the set index to form the BIST tag
  localparam logic [TAG_W-1:0] BIST_SEED = 8'hA5;

  // One way of one set as stored in the memory
  typedef struct packed {
    logic             valid;
    logic             dirty;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  // One bit per way
  typedef logic [NUM_WAYS-1:0] way_vec_t;

  // Request kinds
  typedef enum logic [1:0] {
    OP_LOOKUP,
    OP_FLUSH,
    OP_BIST
  } tag_op_e;

  // Request controller
  typedef enum logic [2:0] {
    IDLE,
    READ,
    RESP,
    WRITE,
    BIST_WAIT
  } ctrl_state_e;

  // BIST sequencer
  typedef enum logic [2:0] {
    B_IDLE,
    B_WRITE,
    B_READ,
    B_CHECK,
    B_CLEAR
  } bist_state_e;

endpackage

// ==== rtl/tag_ram.sv ====
`timescale 1ns/1ps

module tag_ram (
  input  logic                                                 clk_i,
  input  logic                                                 req_i,
  input  tag_store_pkg::way_vec_t                              we_i,
  input  logic [tag_store_pkg::INDEX_W-1:0]                    index_i,
  input  tag_store_pkg::tag_entry_t                            wdata_i,
  output tag_store_pkg::tag_entry_t [tag_store_pkg::NUM_WAYS-1:0] rdata_o
);

  // One word per set, all ways side by side
  tag_store_pkg::tag_entry_t [tag_store_pkg::NUM_WAYS-1:0] mem_q [tag_store_pkg::SETS];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (|we_i) begin
        // Only the enabled ways change
        for (int w = 0; w < tag_store_pkg::NUM_WAYS; w++) begin
          if (we_i[w]) begin
            mem_q[index_i][w] <= wdata_i;
          end
        end
      end else begin
        // Read registers the whole set, held until the next read
        rdata_o <= mem_q[index_i];
      end
    end
  end

endmodule

// ==== rtl/tag_ram_arbiter.sv ====
`timescale 1ns/1ps

module tag_ram_arbiter (
  // BIST engine side, highest priority
  input  logic                              bist_req_i,
  input  tag_store_pkg::way_vec_t           bist_we_i,
  input  logic [tag_store_pkg::INDEX_W-1:0] bist_index_i,
  input  tag_store_pkg::tag_entry_t         bist_wdata_i,
  // Request controller side
  input  logic                              ctrl_req_i,
  input  tag_store_pkg::way_vec_t           ctrl_we_i,
  input  logic [tag_store_pkg::INDEX_W-1:0] ctrl_index_i,
  input  tag_store_pkg::tag_entry_t         ctrl_wdata_i,
  output logic                              bist_gnt_o,
  output logic                              ctrl_gnt_o,
  // Memory command
  output logic                              ram_req_o,
  output tag_store_pkg::way_vec_t           ram_we_o,
  output logic [tag_store_pkg::INDEX_W-1:0] ram_index_o,
  output tag_store_pkg::tag_entry_t         ram_wdata_o
);

  // BIST always wins, the controller waits with its command held
  assign bist_gnt_o = bist_req_i;
  assign ctrl_gnt_o = ctrl_req_i & ~bist_req_i;

  assign ram_req_o = bist_req_i | ctrl_req_i;

  // Only the winner's command reaches the memory
  always_comb begin
    if (bist_req_i) begin
      ram_we_o    = bist_we_i;
      ram_index_o = bist_index_i;
      ram_wdata_o = bist_wdata_i;
    end else begin
      ram_we_o    = ctrl_we_i;
      ram_index_o = ctrl_index_i;
      ram_wdata_o = ctrl_wdata_i;
    end
  end

endmodule

// ==== rtl/evict_select.sv ====
`timescale 1ns/1ps

module evict_select (
  input  logic                                                    clk_i,
  input  logic                                                    rst_i,
  input  tag_store_pkg::tag_entry_t [tag_store_pkg::NUM_WAYS-1:0] entries_i,
  input  tag_store_pkg::way_vec_t                                 spm_lock_i,
  input  logic                                                    advance_i,
  output tag_store_pkg::way_vec_t                                 victim_o
);

  logic [tag_store_pkg::WAY_W-1:0] ptr_q;
  logic [tag_store_pkg::WAY_W-1:0] rr_idx;
  logic [tag_store_pkg::WAY_W-1:0] scan_idx;
  logic                            inv_found;
  logic                            rr_found;
  tag_store_pkg::way_vec_t         inv_vec;
  tag_store_pkg::way_vec_t         rr_vec;

  always_comb begin
    inv_found = 1'b0;
    rr_found  = 1'b0;
    inv_vec   = '0;
    rr_vec    = '0;
    rr_idx    = '0;
    scan_idx  = '0;
    // Lowest unlocked invalid way first
    for (int i = 0; i < tag_store_pkg::NUM_WAYS; i++) begin
      if (!inv_found && !spm_lock_i[i] && !entries_i[i].valid) begin
        inv_found  = 1'b1;
        inv_vec[i] = 1'b1;
      end
    end
    // Otherwise first unlocked way from the pointer on, wrapping
    for (int i = 0; i < tag_store_pkg::NUM_WAYS; i++) begin
      scan_idx = ptr_q + tag_store_pkg::WAY_W'(i);
      if (!rr_found && !spm_lock_i[scan_idx]) begin
        rr_found         = 1'b1;
        rr_vec[scan_idx] = 1'b1;
        rr_idx           = scan_idx;
      end
    end
  end

  // All locked leaves both vectors zero
  assign victim_o = inv_found ? inv_vec : rr_vec;

  // Pointer moves only when the round-robin choice was taken
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (advance_i && !inv_found && rr_found) begin
      ptr_q <= rr_idx + 1'b1;
    end
  end

endmodule

// ==== rtl/bist_engine.sv ====
`timescale 1ns/1ps

module bist_engine (
  input  logic                                                    clk_i,
  input  logic                                                    rst_i,
  input  logic                                                    start_i,
  input  logic                                                    gnt_i,
  input  tag_store_pkg::tag_entry_t [tag_store_pkg::NUM_WAYS-1:0] rdata_i,
  output logic                                                    mem_req_o,
  output tag_store_pkg::way_vec_t                                 mem_we_o,
  output logic [tag_store_pkg::INDEX_W-1:0]                       mem_index_o,
  output tag_store_pkg::tag_entry_t                               mem_wdata_o,
  output logic                                                    done_o,
  output tag_store_pkg::way_vec_t                                 fail_o
);

  tag_store_pkg::bist_state_e       state_q;
  logic [tag_store_pkg::INDEX_W-1:0] idx_q;
  logic                              last_set;
  tag_store_pkg::tag_entry_t         pattern;

  // Expected word for the current set
  assign pattern.valid = 1'b1;
  assign pattern.dirty = 1'b1;
  assign pattern.tag   = tag_store_pkg::TAG_W'(idx_q) ^ tag_store_pkg::BIST_SEED;

  assign last_set = (idx_q == tag_store_pkg::INDEX_W'(tag_store_pkg::SETS - 1));

  // Memory command from the state, held until granted
  assign mem_req_o   = (state_q == tag_store_pkg::B_WRITE) ||
                       (state_q == tag_store_pkg::B_READ)  ||
                       (state_q == tag_store_pkg::B_CLEAR);
  assign mem_we_o    = (state_q == tag_store_pkg::B_READ) ? '0 : '1;
  assign mem_index_o = idx_q;
  assign mem_wdata_o = (state_q == tag_store_pkg::B_CLEAR) ? '0 : pattern;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= tag_store_pkg::B_IDLE;
      idx_q   <= '0;
      done_o  <= 1'b0;
      fail_o  <= '0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        tag_store_pkg::B_IDLE: begin
          // New run clears the old result
          if (start_i) begin
            idx_q   <= '0;
            fail_o  <= '0;
            state_q <= tag_store_pkg::B_WRITE;
          end
        end
        tag_store_pkg::B_WRITE: begin
          // Pass one, pattern into every set
          if (gnt_i) begin
            idx_q <= idx_q + 1'b1;
            if (last_set) begin
              state_q <= tag_store_pkg::B_READ;
            end
          end
        end
        tag_store_pkg::B_READ: begin
          if (gnt_i) begin
            state_q <= tag_store_pkg::B_CHECK;
          end
        end
        tag_store_pkg::B_CHECK: begin
          // Pass two, read data is here one cycle after the read
          for (int w = 0; w < tag_store_pkg::NUM_WAYS; w++) begin
            if (rdata_i[w] != pattern) begin
              fail_o[w] <= 1'b1;
            end
          end
          idx_q   <= idx_q + 1'b1;
          state_q <= last_set ? tag_store_pkg::B_CLEAR : tag_store_pkg::B_READ;
        end
        tag_store_pkg::B_CLEAR: begin
          // Pass three, zero everything then report
          if (gnt_i) begin
            idx_q <= idx_q + 1'b1;
            if (last_set) begin
              done_o  <= 1'b1;
              state_q <= tag_store_pkg::B_IDLE;
            end
          end
        end
        default: state_q <= tag_store_pkg::B_IDLE;
      endcase
    end
  end

endmodule

// ==== rtl/lookup_ctrl.sv ====
`timescale 1ns/1ps

module lookup_ctrl (
  input  logic                                                    clk_i,
  input  logic                                                    rst_i,
  // Request
  input  tag_store_pkg::tag_op_e                                  op_i,
  input  logic [tag_store_pkg::INDEX_W-1:0]                       index_i,
  input  logic [tag_store_pkg::TAG_W-1:0]                         tag_i,
  input  logic                                                    dirty_i,
  input  tag_store_pkg::way_vec_t                                 flush_way_i,
  input  logic                                                    req_valid_i,
  output logic                                                    req_ready_o,
  input  tag_store_pkg::way_vec_t                                 spm_lock_i,
  // Memory read data and victim choice
  input  tag_store_pkg::tag_entry_t [tag_store_pkg::NUM_WAYS-1:0] rdata_i,
  input  tag_store_pkg::way_vec_t                                 victim_i,
  output logic                                                    advance_o,
  // Memory command
  output logic                                                    mem_req_o,
  output tag_store_pkg::way_vec_t                                 mem_we_o,
  output logic [tag_store_pkg::INDEX_W-1:0]                       mem_index_o,
  output tag_store_pkg::tag_entry_t                               mem_wdata_o,
  input  logic                                                    gnt_i,
  // BIST hand-off
  output logic                                                    bist_start_o,
  input  logic                                                    bist_done_i,
  // Response
  output logic                                                    res_valid_o,
  input  logic                                                    res_ready_i,
  output logic                                                    res_hit_o,
  output tag_store_pkg::way_vec_t                                 res_way_o,
  output logic                                                    res_evict_o,
  output logic [tag_store_pkg::TAG_W-1:0]                         res_evict_tag_o
);

  tag_store_pkg::ctrl_state_e       state_q;
  tag_store_pkg::ctrl_state_e       state_d;

  // Request held for the whole transaction
  tag_store_pkg::tag_op_e            op_q;
  logic [tag_store_pkg::INDEX_W-1:0] index_q;
  logic [tag_store_pkg::TAG_W-1:0]   tag_q;
  logic                              dirty_q;
  tag_store_pkg::way_vec_t           flush_way_q;

  // Pending write-back
  tag_store_pkg::way_vec_t           wb_we_q;
  tag_store_pkg::tag_entry_t         wb_data_q;
  tag_store_pkg::tag_entry_t         wb_data;
  logic                              wb_need;

  tag_store_pkg::way_vec_t           hit_vec;
  tag_store_pkg::way_vec_t           sel_vec;
  tag_store_pkg::tag_entry_t         sel_entry;
  logic                              is_lookup;
  logic                              is_hit;
  logic                              accept;
  logic                              res_hsk;

  assign req_ready_o = (state_q == tag_store_pkg::IDLE);
  assign accept      = req_ready_o && req_valid_i;
  assign res_valid_o = (state_q == tag_store_pkg::RESP);
  assign res_hsk     = res_valid_o && res_ready_i;

  // BIST start is a single pulse on acceptance
  assign bist_start_o = accept && (op_i == tag_store_pkg::OP_BIST);

  // Tag compare over all ways at once, locked ways never hit
  always_comb begin
    for (int i = 0; i < tag_store_pkg::NUM_WAYS; i++) begin
      hit_vec[i] = !spm_lock_i[i] && rdata_i[i].valid && (rdata_i[i].tag == tag_q);
    end
  end

  assign is_lookup = (op_q == tag_store_pkg::OP_LOOKUP);
  assign is_hit    = is_lookup && (|hit_vec);

  // Way that the response is about
  assign sel_vec = !is_lookup ? flush_way_q : (is_hit ? hit_vec : victim_i);

  // Entry of the selected way, zero when none is selected
  always_comb begin
    sel_entry = '0;
    for (int i = 0; i < tag_store_pkg::NUM_WAYS; i++) begin
      if (sel_vec[i]) begin
        sel_entry = tag_store_pkg::tag_entry_t'(sel_entry | rdata_i[i]);
      end
    end
  end

  // Read data stays in the memory register, so these hold under back-pressure
  assign res_hit_o       = is_hit;
  assign res_way_o       = sel_vec;
  assign res_evict_o     = !is_hit && sel_entry.valid && sel_entry.dirty;
  assign res_evict_tag_o = is_hit ? '0 : sel_entry.tag;

  // Hit writes only to mark clean as dirty; miss and flush write when a way is chosen
  assign wb_need = is_hit ? (dirty_q && !sel_entry.dirty) : (|sel_vec);

  always_comb begin
    wb_data = '0;
    if (is_lookup) begin
      wb_data.valid = 1'b1;
      wb_data.dirty = dirty_q;
      wb_data.tag   = tag_q;
    end
  end

  // Round-robin moves once per miss response
  assign advance_o = res_hsk && is_lookup && !is_hit;

  // Memory command
  assign mem_req_o   = (state_q == tag_store_pkg::READ) || (state_q == tag_store_pkg::WRITE);
  assign mem_we_o    = (state_q == tag_store_pkg::WRITE) ? wb_we_q : '0;
  assign mem_index_o = index_q;
  assign mem_wdata_o = wb_data_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      tag_store_pkg::IDLE: begin
        if (accept) begin
          state_d = (op_i == tag_store_pkg::OP_BIST) ? tag_store_pkg::BIST_WAIT
                                                     : tag_store_pkg::READ;
        end
      end
      tag_store_pkg::READ: begin
        if (gnt_i) begin
          state_d = tag_store_pkg::RESP;
        end
      end
      tag_store_pkg::RESP: begin
        if (res_hsk) begin
          state_d = wb_need ? tag_store_pkg::WRITE : tag_store_pkg::IDLE;
        end
      end
      tag_store_pkg::WRITE: begin
        if (gnt_i) begin
          state_d = tag_store_pkg::IDLE;
        end
      end
      tag_store_pkg::BIST_WAIT: begin
        if (bist_done_i) begin
          state_d = tag_store_pkg::IDLE;
        end
      end
      default: state_d = tag_store_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= tag_store_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q        <= op_i;
      index_q     <= index_i;
      tag_q       <= tag_i;
      dirty_q     <= dirty_i;
      flush_way_q <= flush_way_i;
    end
    // Captured before the pointer moves
    if (res_hsk) begin
      wb_we_q   <= sel_vec;
      wb_data_q <= wb_data;
    end
  end

endmodule

// ==== rtl/tag_store_top.sv ====
`timescale 1ns/1ps

module tag_store_top (
  input  logic                              clk_i,
  input  logic                              rst_i,
  // Request
  input  tag_store_pkg::tag_op_e            op_i,
  input  logic [tag_store_pkg::INDEX_W-1:0] index_i,
  input  logic [tag_store_pkg::TAG_W-1:0]   tag_i,
  input  logic                              dirty_i,
  input  tag_store_pkg::way_vec_t           flush_way_i,
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  // Response
  output logic                              res_valid_o,
  input  logic                              res_ready_i,
  output logic                              res_hit_o,
  output tag_store_pkg::way_vec_t           res_way_o,
  output logic                              res_evict_o,
  output logic [tag_store_pkg::TAG_W-1:0]   res_evict_tag_o,
  // Scratchpad ways and BIST result
  input  tag_store_pkg::way_vec_t           spm_lock_i,
  output logic                              bist_done_o,
  output tag_store_pkg::way_vec_t           bist_fail_o
);

  // BIST engine command
  logic                                                    bist_req;
  tag_store_pkg::way_vec_t                                 bist_we;
  logic [tag_store_pkg::INDEX_W-1:0]                       bist_index;
  tag_store_pkg::tag_entry_t                               bist_wdata;
  logic                                                    bist_gnt;
  logic                                                    bist_start;
  // Controller command
  logic                                                    ctrl_req;
  tag_store_pkg::way_vec_t                                 ctrl_we;
  logic [tag_store_pkg::INDEX_W-1:0]                       ctrl_index;
  tag_store_pkg::tag_entry_t                               ctrl_wdata;
  logic                                                    ctrl_gnt;
  // Memory side
  logic                                                    ram_req;
  tag_store_pkg::way_vec_t                                 ram_we;
  logic [tag_store_pkg::INDEX_W-1:0]                       ram_index;
  tag_store_pkg::tag_entry_t                               ram_wdata;
  tag_store_pkg::tag_entry_t [tag_store_pkg::NUM_WAYS-1:0] ram_rdata;
  // Victim choice
  tag_store_pkg::way_vec_t                                 victim;
  logic                                                    advance;

  tag_ram i_tag_ram (
    .clk_i   (clk_i),
    .req_i   (ram_req),
    .we_i    (ram_we),
    .index_i (ram_index),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

  tag_ram_arbiter i_arbiter (
    .bist_req_i   (bist_req),
    .bist_we_i    (bist_we),
    .bist_index_i (bist_index),
    .bist_wdata_i (bist_wdata),
    .ctrl_req_i   (ctrl_req),
    .ctrl_we_i    (ctrl_we),
    .ctrl_index_i (ctrl_index),
    .ctrl_wdata_i (ctrl_wdata),
    .bist_gnt_o   (bist_gnt),
    .ctrl_gnt_o   (ctrl_gnt),
    .ram_req_o    (ram_req),
    .ram_we_o     (ram_we),
    .ram_index_o  (ram_index),
    .ram_wdata_o  (ram_wdata)
  );

  evict_select i_evict_select (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .entries_i  (ram_rdata),
    .spm_lock_i (spm_lock_i),
    .advance_i  (advance),
    .victim_o   (victim)
  );

  bist_engine i_bist_engine (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .start_i     (bist_start),
    .gnt_i       (bist_gnt),
    .rdata_i     (ram_rdata),
    .mem_req_o   (bist_req),
    .mem_we_o    (bist_we),
    .mem_index_o (bist_index),
    .mem_wdata_o (bist_wdata),
    .done_o      (bist_done_o),
    .fail_o      (bist_fail_o)
  );

  lookup_ctrl i_lookup_ctrl (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .op_i            (op_i),
    .index_i         (index_i),
    .tag_i           (tag_i),
    .dirty_i         (dirty_i),
    .flush_way_i     (flush_way_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .spm_lock_i      (spm_lock_i),
    .rdata_i         (ram_rdata),
    .victim_i        (victim),
    .advance_o       (advance),
    .mem_req_o       (ctrl_req),
    .mem_we_o        (ctrl_we),
    .mem_index_o     (ctrl_index),
    .mem_wdata_o     (ctrl_wdata),
    .gnt_i           (ctrl_gnt),
    .bist_start_o    (bist_start),
    .bist_done_i     (bist_done_o),
    .res_valid_o     (res_valid_o),
    .res_ready_i     (res_ready_i),
    .res_hit_o       (res_hit_o),
    .res_way_o       (res_way_o),
    .res_evict_o     (res_evict_o),
    .res_evict_tag_o (res_evict_tag_o)
  );

endmodule

// ==== verif/tag_store_properties.sv ====
`timescale 1ns/1ps

module tag_store_properties (
  input logic                            clk_i,
  input logic                            rst_i,
  input logic                            req_ready_o,
  input logic                            res_valid_o,
  input logic                            res_ready_i,
  input logic                            res_hit_o,
  input tag_store_pkg::way_vec_t         res_way_o,
  input logic                            res_evict_o,
  input logic [tag_store_pkg::TAG_W-1:0] res_evict_tag_o
);

  // Stalled response keeps valid and every field
  assert property (@(posedge clk_i) disable iff (rst_i)
    (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_hit_o) &&
      $stable(res_way_o) && $stable(res_evict_o) && $stable(res_evict_tag_o)))
    else $error("response changed while res_ready_i was low");

  // At most one way named in a response
  assert property (@(posedge clk_i) disable iff (rst_i)
    res_valid_o |-> $onehot0(res_way_o))
    else $error("res_way_o has more than one bit set");

  // No new request while a response is pending
  assert property (@(posedge clk_i) disable iff (rst_i)
    res_valid_o |-> !req_ready_o)
    else $error("req_ready_o high during a response");

endmodule

bind tag_store_top tag_store_properties properties_i (
  .clk_i           (clk_i),
  .rst_i           (rst_i),
  .req_ready_o     (req_ready_o),
  .res_valid_o     (res_valid_o),
  .res_ready_i     (res_ready_i),
  .res_hit_o       (res_hit_o),
  .res_way_o       (res_way_o),
  .res_evict_o     (res_evict_o),
  .res_evict_tag_o (res_evict_tag_o)
);

// ==== verif/tag_store_tb.sv ====
`timescale 1ns/1ps

module tag_store_tb;

  localparam int NUM_ROWS    = 27;
  // 40 cycles per row plus room for the BIST runs
  localparam int CYCLE_LIMIT = NUM_ROWS * 40 + 200;

  logic                              clk_i;
  logic                              rst_i;
  tag_store_pkg::tag_op_e            op_i;
  logic [tag_store_pkg::INDEX_W-1:0] index_i;
  logic [tag_store_pkg::TAG_W-1:0]   tag_i;
  logic                              dirty_i;
  tag_store_pkg::way_vec_t           flush_way_i;
  logic                              req_valid_i;
  logic                              req_ready_o;
  logic                              res_valid_o;
  logic                              res_ready_i;
  logic                              res_hit_o;
  tag_store_pkg::way_vec_t           res_way_o;
  logic                              res_evict_o;
  logic [tag_store_pkg::TAG_W-1:0]   res_evict_tag_o;
  tag_store_pkg::way_vec_t           spm_lock_i;
  logic                              bist_done_o;
  tag_store_pkg::way_vec_t           bist_fail_o;

  // Stimulus columns
  tag_store_pkg::tag_op_e            op_tab    [NUM_ROWS];
  logic [tag_store_pkg::INDEX_W-1:0] index_tab [NUM_ROWS];
  logic [tag_store_pkg::TAG_W-1:0]   tag_tab   [NUM_ROWS];
  logic                              dirty_tab [NUM_ROWS];
  tag_store_pkg::way_vec_t           flush_tab [NUM_ROWS];
  tag_store_pkg::way_vec_t           lock_tab  [NUM_ROWS];
  // Expected columns, for BIST rows way holds the expected fail vector
  logic                              hit_tab   [NUM_ROWS];
  tag_store_pkg::way_vec_t           way_tab   [NUM_ROWS];
  logic                              evict_tab [NUM_ROWS];
  logic [tag_store_pkg::TAG_W-1:0]   etag_tab  [NUM_ROWS];

  int     n_rows      = 0;
  int     errors      = 0;
  int     rows_failed = 0;
  int     responses   = 0;
  int     cycles      = 0;
  integer seed;

  tag_store_top dut_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .op_i            (op_i),
    .index_i         (index_i),
    .tag_i           (tag_i),
    .dirty_i         (dirty_i),
    .flush_way_i     (flush_way_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .res_valid_o     (res_valid_o),
    .res_ready_i     (res_ready_i),
    .res_hit_o       (res_hit_o),
    .res_way_o       (res_way_o),
    .res_evict_o     (res_evict_o),
    .res_evict_tag_o (res_evict_tag_o),
    .spm_lock_i      (spm_lock_i),
    .bist_done_o     (bist_done_o),
    .bist_fail_o     (bist_fail_o)
  );

  always #50 clk_i = ~clk_i;

  // Hard stop if the DUT stops answering
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout reached after %0d cycles, the DUT stopped answering", cycles);
      $display("test failed");
      $finish;
    end
  end

  // Completed response handshakes, sampled mid-cycle
  always @(negedge clk_i) begin
    if (!rst_i && res_valid_o && res_ready_i) begin
      responses <= responses + 1;
    end
  end

  task automatic add_lookup(input logic [tag_store_pkg::INDEX_W-1:0] idx,
                            input logic [tag_store_pkg::TAG_W-1:0] tag,
                            input logic dirty,
                            input tag_store_pkg::way_vec_t lock,
                            input logic hit,
                            input tag_store_pkg::way_vec_t way,
                            input logic evict,
                            input logic [tag_store_pkg::TAG_W-1:0] etag);
    op_tab[n_rows]    = tag_store_pkg::OP_LOOKUP;
    index_tab[n_rows] = idx;
    tag_tab[n_rows]   = tag;
    dirty_tab[n_rows] = dirty;
    flush_tab[n_rows] = '0;
    lock_tab[n_rows]  = lock;
    hit_tab[n_rows]   = hit;
    way_tab[n_rows]   = way;
    evict_tab[n_rows] = evict;
    etag_tab[n_rows]  = etag;
    n_rows++;
  endtask

  // Flush never hits and always names the flushed way
  task automatic add_flush(input logic [tag_store_pkg::INDEX_W-1:0] idx,
                           input tag_store_pkg::way_vec_t way,
                           input tag_store_pkg::way_vec_t lock,
                           input logic evict,
                           input logic [tag_store_pkg::TAG_W-1:0] etag);
    op_tab[n_rows]    = tag_store_pkg::OP_FLUSH;
    index_tab[n_rows] = idx;
    tag_tab[n_rows]   = '0;
    dirty_tab[n_rows] = 1'b0;
    flush_tab[n_rows] = way;
    lock_tab[n_rows]  = lock;
    hit_tab[n_rows]   = 1'b0;
    way_tab[n_rows]   = way;
    evict_tab[n_rows] = evict;
    etag_tab[n_rows]  = etag;
    n_rows++;
  endtask

  task automatic add_bist();
    op_tab[n_rows]    = tag_store_pkg::OP_BIST;
    index_tab[n_rows] = '0;
    tag_tab[n_rows]   = '0;
    dirty_tab[n_rows] = 1'b0;
    flush_tab[n_rows] = '0;
    lock_tab[n_rows]  = '0;
    hit_tab[n_rows]   = 1'b0;
    way_tab[n_rows]   = '0;
    evict_tab[n_rows] = 1'b0;
    etag_tab[n_rows]  = '0;
    n_rows++;
  endtask

  task automatic fill_table();
    // Memory starts unknown, BIST clears it
    add_bist();
    add_lookup(4'd3, 8'h11, 1'b0, 4'b0000, 1'b0, 4'b0001, 1'b0, 8'h00);
    // Fill set 5, invalid ways taken lowest first
    add_lookup(4'd5, 8'h20, 1'b0, 4'b0000, 1'b0, 4'b0001, 1'b0, 8'h00);
    add_lookup(4'd5, 8'h21, 1'b0, 4'b0000, 1'b0, 4'b0010, 1'b0, 8'h00);
    add_lookup(4'd5, 8'h22, 1'b0, 4'b0000, 1'b0, 4'b0100, 1'b0, 8'h00);
    add_lookup(4'd5, 8'h23, 1'b0, 4'b0000, 1'b0, 4'b1000, 1'b0, 8'h00);
    add_lookup(4'd5, 8'h20, 1'b0, 4'b0000, 1'b1, 4'b0001, 1'b0, 8'h00);
    add_lookup(4'd5, 8'h21, 1'b0, 4'b0000, 1'b1, 4'b0010, 1'b0, 8'h00);
    add_lookup(4'd5, 8'h22, 1'b0, 4'b0000, 1'b1, 4'b0100, 1'b0, 8'h00);
    add_lookup(4'd5, 8'h23, 1'b0, 4'b0000, 1'b1, 4'b1000, 1'b0, 8'h00);
    // Way 0 turns dirty, then round robin from pointer 0 evicts it
    add_lookup(4'd5, 8'h20, 1'b1, 4'b0000, 1'b1, 4'b0001, 1'b0, 8'h00);
    add_lookup(4'd5, 8'h24, 1'b0, 4'b0000, 1'b0, 4'b0001, 1'b1, 8'h20);
    add_lookup(4'd5, 8'h25, 1'b0, 4'b0000, 1'b0, 4'b0010, 1'b0, 8'h21);
    // Dirty way 2 flushed, then refilled as the only invalid way
    add_lookup(4'd5, 8'h22, 1'b1, 4'b0000, 1'b1, 4'b0100, 1'b0, 8'h00);
    add_flush(4'd5, 4'b0100, 4'b0000, 1'b1, 8'h22);
    add_lookup(4'd5, 8'h22, 1'b0, 4'b0000, 1'b0, 4'b0100, 1'b0, 8'h00);
    // Way 0 locked, its tag misses and round robin skips it
    add_lookup(4'd5, 8'h24, 1'b0, 4'b0001, 1'b0, 4'b0100, 1'b0, 8'h22);
    add_lookup(4'd5, 8'h26, 1'b0, 4'b0001, 1'b0, 4'b1000, 1'b0, 8'h23);
    add_lookup(4'd5, 8'h27, 1'b0, 4'b0001, 1'b0, 4'b0010, 1'b0, 8'h25);
    add_lookup(4'd9, 8'h40, 1'b0, 4'b0001, 1'b0, 4'b0010, 1'b0, 8'h00);
    // Dirty miss, flush, and refill in set 3
    add_lookup(4'd3, 8'h28, 1'b1, 4'b0000, 1'b0, 4'b0010, 1'b0, 8'h00);
    add_flush(4'd3, 4'b0010, 4'b0000, 1'b1, 8'h28);
    add_lookup(4'd3, 8'h11, 1'b0, 4'b0000, 1'b1, 4'b0001, 1'b0, 8'h00);
    add_lookup(4'd3, 8'h28, 1'b0, 4'b0000, 1'b0, 4'b0010, 1'b0, 8'h00);
    // Clean flush still reports the stored tag
    add_flush(4'd5, 4'b1000, 4'b0001, 1'b0, 8'h26);
    // Second BIST wipes filled sets
    add_bist();
    add_lookup(4'd5, 8'h30, 1'b0, 4'b0000, 1'b0, 4'b0001, 1'b0, 8'h00);
  endtask

  task automatic report_mismatch(input int r, input string msg);
    $display("** Error at time %0t: row %0d %s", $time, r, msg);
    errors++;
  endtask

  // To the drive point of the next cycle, with a fresh ready bit
  task automatic next_cycle();
    int rnd;
    @(posedge clk_i);
    #1;
    rnd = $random(seed);
    res_ready_i = rnd[0];
  endtask

  task automatic send_request(input int r);
    logic taken;
    next_cycle();
    op_i        = op_tab[r];
    index_i     = index_tab[r];
    tag_i       = tag_tab[r];
    dirty_i     = dirty_tab[r];
    flush_way_i = flush_tab[r];
    // Lock stays applied until the next row
    spm_lock_i  = lock_tab[r];
    req_valid_i = 1'b1;
    do begin
      @(negedge clk_i);
      taken = req_ready_o;
      next_cycle();
    end while (!taken);
    req_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    logic ready;
    ready = 1'b0;
    while (!ready) begin
      @(negedge clk_i);
      ready = req_ready_o;
      if (!ready) begin
        next_cycle();
      end
    end
  endtask

  task automatic run_row(input int r);
    int                              errors_before;
    int                              resp_before;
    logic                            done;
    logic                            got_hit;
    tag_store_pkg::way_vec_t         got_way;
    logic                            got_evict;
    logic [tag_store_pkg::TAG_W-1:0] got_etag;
    errors_before = errors;
    resp_before   = responses;
    send_request(r);
    if (op_tab[r] == tag_store_pkg::OP_BIST) begin
      // Fail vector is valid with the done pulse
      do begin
        @(negedge clk_i);
        done    = bist_done_o;
        got_way = bist_fail_o;
        if (!done) begin
          next_cycle();
        end
      end while (!done);
      wait_idle();
      assert (got_way == way_tab[r])
        else report_mismatch(r, $sformatf("bist fail %b, expected %b", got_way, way_tab[r]));
      assert (responses == resp_before)
        else report_mismatch(r, "BIST request produced a response");
    end else begin
      do begin
        @(negedge clk_i);
        done      = res_valid_o && res_ready_i;
        got_hit   = res_hit_o;
        got_way   = res_way_o;
        got_evict = res_evict_o;
        got_etag  = res_evict_tag_o;
        next_cycle();
      end while (!done);
      wait_idle();
      assert (got_hit == hit_tab[r])
        else report_mismatch(r, $sformatf("hit %b, expected %b", got_hit, hit_tab[r]));
      assert (got_way == way_tab[r])
        else report_mismatch(r, $sformatf("way %b, expected %b", got_way, way_tab[r]));
      assert (got_evict == evict_tab[r])
        else report_mismatch(r, $sformatf("evict %b, expected %b", got_evict, evict_tab[r]));
      assert (got_etag == etag_tab[r])
        else report_mismatch(r, $sformatf("evict tag %h, expected %h", got_etag, etag_tab[r]));
      // Exactly one handshake per request
      assert (responses == resp_before + 1)
        else report_mismatch(r, $sformatf("%0d responses, expected 1", responses - resp_before));
    end
    if (errors != errors_before) begin
      rows_failed++;
    end
    $display("row %0d %s: %s", r, op_tab[r].name(), (errors == errors_before) ? "ok" : "mismatch");
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    op_i        = tag_store_pkg::OP_LOOKUP;
    index_i     = '0;
    tag_i       = '0;
    dirty_i     = 1'b0;
    flush_way_i = '0;
    req_valid_i = 1'b0;
    res_ready_i = 1'b0;
    spm_lock_i  = '0;
    seed        = 32'h3a55;
    fill_table();
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    $display("rows %0d, rows failed %0d, errors %0d, responses %0d",
             n_rows, rows_failed, errors, responses);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
rtl/tag_store_pkg.sv
rtl/tag_ram.sv
rtl/tag_ram_arbiter.sv
rtl/evict_select.sv
rtl/bist_engine.sv
rtl/lookup_ctrl.sv
rtl/tag_store_top.sv
verif/tag_store_properties.sv
verif/tag_store_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tag_store_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert
PASS_MSG  ?= test passed

.PHONY: run build lint clean

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
